// ==== verilog/mipsPkg.sv ====
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Basic datapath types
    ////////////////////////////////////////////////////////////

    // Data word, also a byte address
    typedef logic [31:0] word_t;

    // Architectural register number
    typedef logic [4:0] regIdx_t;

    // ALU operations
    // Pass-B is the idle code for bubbles, branches and jumps
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_SLT   = 3'd4,
        ALU_PASSB = 3'd5
    } aluOp_t;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit #(
    parameter int imemWords = 256
) (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [$clog2(imemWords)-1:0] loadAddr,
    input  mipsPkg::word_t               loadData,
    input  logic                         stall,
    input  logic                         pcRedirect,
    input  mipsPkg::word_t               redirectTarget,
    output mipsPkg::word_t               idInstr,
    output mipsPkg::word_t               idPcPlus4
);
    import mipsPkg::*;

    localparam int iAddrW = $clog2(imemWords);

    word_t imem [imemWords];
    word_t pc;
    word_t pcPlus4;
    word_t fetchInstr;

    assign pcPlus4 = pc + 32'd4;

    // Word index from the byte PC
    assign fetchInstr = imem[pc[iAddrW+1:2]];

    // Program load port
    always_ff @(posedge Clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    ////////////////////////////////////////////////////////////
    // PC and fetch/decode register
    ////////////////////////////////////////////////////////////

    // Stall holds the PC, otherwise redirect or step
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pcRedirect ? redirectTarget : pcPlus4;
        end
    end

    // All-zero word decodes as a no-op
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            idInstr   <= '0;
            idPcPlus4 <= '0;
        end else if (!run || (pcRedirect && !stall)) begin
            // Wrong-path slot after a taken branch
            idInstr   <= '0;
            idPcPlus4 <= '0;
        end else if (!stall) begin
            idInstr   <= fetchInstr;
            idPcPlus4 <= pcPlus4;
        end
    end

    // Instruction memory only changes while halted
    loadWhileHalted: assert property (@(posedge Clk) disable iff (!arstN) !(loadEn && run));

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::regIdx_t idRs,
    input  mipsPkg::regIdx_t idRt,
    input  mipsPkg::regIdx_t exDest,
    input  mipsPkg::regIdx_t memDest,
    input  logic             exRegWrite,
    input  logic             memRegWrite,
    input  logic             usesRt,
    output logic             stall
);
    import mipsPkg::*;

    logic rsPending;
    logic rtPending;

    // No forwarding paths, so any pending write to a source must drain
    // Writeback stage is covered by the write-through register file
    always_comb begin
        rsPending = (exRegWrite && exDest == idRs) || (memRegWrite && memDest == idRs);
        rtPending = (exRegWrite && exDest == idRt) || (memRegWrite && memDest == idRt);
    end

    // Register 0 never carries a dependence
    // rt only matters for R-type, stores and branches
    assign stall = (rsPending && idRs != '0)
                 || (rtPending && idRt != '0 && usesRt);

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic             Clk,
    input  logic             arstN,
    input  mipsPkg::regIdx_t rdAddrA,
    input  mipsPkg::regIdx_t rdAddrB,
    input  mipsPkg::regIdx_t wrAddr,
    input  mipsPkg::word_t   wrData,
    input  logic             wrEn,
    output mipsPkg::word_t   rdDataA,
    output mipsPkg::word_t   rdDataB
);
    import mipsPkg::*;

    word_t regs [32];

    // Register 0 stays zero, writes to it are dropped
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle write is visible to decode
    function automatic word_t readPort(regIdx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && wrAddr == addr) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    // Read ports follow the array and the write port too
    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    // Writeback stage filters out register 0 before the strobe
    noZeroWrite: assert property (@(posedge Clk) disable iff (!arstN) wrEn |-> wrAddr != '0);

endmodule

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             run,
    input  mipsPkg::word_t   idInstr,
    input  mipsPkg::word_t   idPcPlus4,
    input  mipsPkg::regIdx_t wrAddr,
    input  mipsPkg::word_t   wrData,
    input  logic             wrEn,
    input  mipsPkg::regIdx_t memDest,
    input  logic             memRegWrite,
    output logic             stall,
    output logic             pcRedirect,
    output mipsPkg::word_t   redirectTarget,
    output mipsPkg::aluOp_t  exAluOp,
    output logic             exUseImm,
    output mipsPkg::word_t   exOpA,
    output mipsPkg::word_t   exOpB,
    output mipsPkg::word_t   exImm,
    output mipsPkg::word_t   exStoreData,
    output mipsPkg::regIdx_t exDest,
    output logic             exRegWrite,
    output logic             exMemRead,
    output logic             exMemWrite
);
    import mipsPkg::*;

    // Instruction fields
    logic [5:0] opcode;
    logic [5:0] funct;
    regIdx_t    rs;
    regIdx_t    rt;
    regIdx_t    rd;

    assign opcode = idInstr[31:26];
    assign rs     = idInstr[25:21];
    assign rt     = idInstr[20:16];
    assign rd     = idInstr[15:11];
    assign funct  = idInstr[5:0];

    // Decoded controls
    aluOp_t  aluOp;
    regIdx_t dest;
    logic    useImm;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    usesRt;
    logic    zeroExt;
    logic    isBeq;
    logic    isBne;
    logic    isJump;

    word_t rdDataA;
    word_t rdDataB;
    word_t immExt;
    logic  regsEqual;

    ////////////////////////////////////////////////////////////
    // Register file and stall detection
    ////////////////////////////////////////////////////////////

    regFile uRegFile (
        .Clk     (Clk),
        .arstN   (arstN),
        .rdAddrA (rs),
        .rdAddrB (rt),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (wrEn),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    hazardUnit uHazard (
        .idRs        (rs),
        .idRt        (rt),
        .exDest      (exDest),
        .memDest     (memDest),
        .exRegWrite  (exRegWrite),
        .memRegWrite (memRegWrite),
        .usesRt      (usesRt),
        .stall       (stall)
    );

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        aluOp    = ALU_PASSB;
        dest     = rt;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        usesRt   = 1'b0;
        zeroExt  = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest   = rd;
                usesRt = 1'b1;
                // Unknown function codes fall through as no-ops
                regWrite = 1'b1;
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: regWrite = 1'b0;
                endcase
            end
            OP_ADDI: begin
                aluOp    = ALU_ADD;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OP_ORI: begin
                aluOp    = ALU_OR;
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            OP_LW: begin
                aluOp    = ALU_ADD;
                useImm   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
            end
            OP_SW: begin
                aluOp    = ALU_ADD;
                useImm   = 1'b1;
                memWrite = 1'b1;
                usesRt   = 1'b1;
            end
            OP_BEQ: begin
                isBeq  = 1'b1;
                usesRt = 1'b1;
            end
            OP_BNE: begin
                isBne  = 1'b1;
                usesRt = 1'b1;
            end
            OP_J:    isJump = 1'b1;
            default: ;
        endcase
    end

    // Immediate, zero-extended only for ori
    assign immExt = zeroExt ? {16'b0, idInstr[15:0]} : {{16{idInstr[15]}}, idInstr[15:0]};

    ////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////

    assign regsEqual  = (rdDataA == rdDataB);
    assign pcRedirect = isJump || (isBeq && regsEqual) || (isBne && !regsEqual);

    // Jump keeps the PC+4 region, branch is PC+4 relative
    assign redirectTarget = isJump ? {idPcPlus4[31:28], idInstr[25:0], 2'b00}
                                   : idPcPlus4 + {immExt[29:0], 2'b00};

    // Decode/execute controls, bubble on stall or halt
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            exAluOp    <= ALU_PASSB;
            exUseImm   <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else if (!run || stall) begin
            exAluOp    <= ALU_PASSB;
            exUseImm   <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exAluOp    <= aluOp;
            exUseImm   <= useImm;
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    // Operands, qualified by the controls above
    always_ff @(posedge Clk) begin
        exOpA       <= rdDataA;
        exOpB       <= rdDataB;
        exImm       <= immExt;
        exStoreData <= rdDataB;
        exDest      <= dest;
    end

endmodule

// ==== verilog/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             run,
    input  mipsPkg::aluOp_t  exAluOp,
    input  logic             exUseImm,
    input  mipsPkg::word_t   exOpA,
    input  mipsPkg::word_t   exOpB,
    input  mipsPkg::word_t   exImm,
    input  mipsPkg::word_t   exStoreData,
    input  mipsPkg::regIdx_t exDest,
    input  logic             exRegWrite,
    input  logic             exMemRead,
    input  logic             exMemWrite,
    output mipsPkg::word_t   memAlu,
    output mipsPkg::word_t   memStoreData,
    output mipsPkg::regIdx_t memDest,
    output logic             memRegWrite,
    output logic             memRead,
    output logic             memWrite
);
    import mipsPkg::*;

    word_t opB;
    word_t aluResult;

    assign opB = exUseImm ? exImm : exOpB;

    // ALU, wrapping arithmetic
    always_comb begin
        case (exAluOp)
            ALU_ADD:   aluResult = exOpA + opB;
            ALU_SUB:   aluResult = exOpA - opB;
            ALU_AND:   aluResult = exOpA & opB;
            ALU_OR:    aluResult = exOpA | opB;
            // Signed compare
            ALU_SLT:   aluResult = {31'b0, $signed(exOpA) < $signed(opB)};
            default:   aluResult = opB;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
        end else if (!run) begin
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
        end
    end

    always_ff @(posedge Clk) begin
        memAlu       <= aluResult;
        memStoreData <= exStoreData;
        memDest      <= exDest;
    end

    // Decode only ever issues the six defined codes
    knownAluOp: assert property (@(posedge Clk) disable iff (!arstN)
        exAluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASSB});

endmodule

// ==== verilog/memoryUnit.sv ====
`timescale 1ns/1ps

module memoryUnit #(
    parameter int dmemWords = 64
) (
    input  logic             Clk,
    input  logic             arstN,
    input  logic             run,
    input  mipsPkg::word_t   memAlu,
    input  mipsPkg::word_t   memStoreData,
    input  mipsPkg::regIdx_t memDest,
    input  logic             memRegWrite,
    input  logic             memRead,
    input  logic             memWrite,
    output logic             wbValid,
    output mipsPkg::regIdx_t wbReg,
    output mipsPkg::word_t   wbData
);
    import mipsPkg::*;

    localparam int dAddrW = $clog2(dmemWords);

    word_t            dmem [dmemWords];
    logic [dAddrW-1:0] dIdx;
    word_t            loadData;

    // Word address folded into the memory size
    assign dIdx     = dAddrW'(memAlu[31:2] % dmemWords);
    assign loadData = dmem[dIdx];

    // Store lands as it leaves the memory stage
    always_ff @(posedge Clk) begin
        if (memWrite) begin
            dmem[dIdx] <= memStoreData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory/writeback register
    ////////////////////////////////////////////////////////////

    // Strobe doubles as the register file write enable
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= run && memRegWrite && memDest != '0;
        end
    end

    always_ff @(posedge Clk) begin
        wbReg  <= memDest;
        wbData <= memRead ? loadData : memAlu;
    end

endmodule

// ==== verilog/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore #(
    parameter int imemWords = 256,
    parameter int dmemWords = 64
) (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic                         run,
    input  logic                         loadEn,
    input  logic [$clog2(imemWords)-1:0] loadAddr,
    input  mipsPkg::word_t               loadData,
    output logic                         wbValid,
    output mipsPkg::regIdx_t             wbReg,
    output mipsPkg::word_t               wbData
);
    import mipsPkg::*;

    // Fetch to decode
    word_t idInstr;
    word_t idPcPlus4;
    logic  stall;
    logic  pcRedirect;
    word_t redirectTarget;

    // Decode to execute
    aluOp_t  exAluOp;
    logic    exUseImm;
    word_t   exOpA;
    word_t   exOpB;
    word_t   exImm;
    word_t   exStoreData;
    regIdx_t exDest;
    logic    exRegWrite;
    logic    exMemRead;
    logic    exMemWrite;

    // Execute to memory
    word_t   memAlu;
    word_t   memStoreData;
    regIdx_t memDest;
    logic    memRegWrite;
    logic    memRead;
    logic    memWrite;

    ////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////

    fetchUnit #(.imemWords(imemWords)) uFetch (
        .Clk            (Clk),
        .arstN          (arstN),
        .run            (run),
        .loadEn         (loadEn),
        .loadAddr       (loadAddr),
        .loadData       (loadData),
        .stall          (stall),
        .pcRedirect     (pcRedirect),
        .redirectTarget (redirectTarget),
        .idInstr        (idInstr),
        .idPcPlus4      (idPcPlus4)
    );

    // Writeback port feeds the register file in decode
    decodeUnit uDecode (
        .Clk            (Clk),
        .arstN          (arstN),
        .run            (run),
        .idInstr        (idInstr),
        .idPcPlus4      (idPcPlus4),
        .wrAddr         (wbReg),
        .wrData         (wbData),
        .wrEn           (wbValid),
        .memDest        (memDest),
        .memRegWrite    (memRegWrite),
        .stall          (stall),
        .pcRedirect     (pcRedirect),
        .redirectTarget (redirectTarget),
        .exAluOp        (exAluOp),
        .exUseImm       (exUseImm),
        .exOpA          (exOpA),
        .exOpB          (exOpB),
        .exImm          (exImm),
        .exStoreData    (exStoreData),
        .exDest         (exDest),
        .exRegWrite     (exRegWrite),
        .exMemRead      (exMemRead),
        .exMemWrite     (exMemWrite)
    );

    executeUnit uExecute (
        .Clk          (Clk),
        .arstN        (arstN),
        .run          (run),
        .exAluOp      (exAluOp),
        .exUseImm     (exUseImm),
        .exOpA        (exOpA),
        .exOpB        (exOpB),
        .exImm        (exImm),
        .exStoreData  (exStoreData),
        .exDest       (exDest),
        .exRegWrite   (exRegWrite),
        .exMemRead    (exMemRead),
        .exMemWrite   (exMemWrite),
        .memAlu       (memAlu),
        .memStoreData (memStoreData),
        .memDest      (memDest),
        .memRegWrite  (memRegWrite),
        .memRead      (memRead),
        .memWrite     (memWrite)
    );

    memoryUnit #(.dmemWords(dmemWords)) uMemory (
        .Clk          (Clk),
        .arstN        (arstN),
        .run          (run),
        .memAlu       (memAlu),
        .memStoreData (memStoreData),
        .memDest      (memDest),
        .memRegWrite  (memRegWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData)
    );

endmodule

// ==== sim/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

////////////////////////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////////////////////////

function automatic word_t encodeR(logic [5:0] fn, regIdx_t rd, regIdx_t rs, regIdx_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t encodeI(logic [5:0] op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Only r0..r7, so dependences are frequent
function automatic regIdx_t pickReg();
    return regIdx_t'($urandom_range(7, 0));
endfunction

////////////////////////////////////////////////////////////
// Random program
////////////////////////////////////////////////////////////

task automatic buildProgram();
    int         kind;
    int         skip;
    int         slot;
    logic [5:0] fn;
    // Every data slot gets a known value before any load
    for (int i = 0; i < nSlots; i++) begin
        prog[i] = encodeI(OP_SW, 5'd0, 5'd0, 16'(i * 4));
    end
    for (int i = nSlots; i < progLen - 1; i++) begin
        kind = int'($urandom_range(99, 0));
        skip = int'($urandom_range(3, 1));
        slot = int'($urandom_range(nSlots - 1, 0));
        // Branch target stays at or before the final jump
        if (kind >= 84 && i + skip > progLen - 2) begin
            skip = progLen - 2 - i;
            if (skip < 1) begin
                kind = 45;
            end
        end
        case (int'($urandom_range(4, 0)))
            0:       fn = FN_ADD;
            1:       fn = FN_SUB;
            2:       fn = FN_AND;
            3:       fn = FN_OR;
            default: fn = FN_SLT;
        endcase
        if (kind < 40) begin
            prog[i] = encodeR(fn, pickReg(), pickReg(), pickReg());
        end else if (kind < 52) begin
            prog[i] = encodeI(OP_ADDI, pickReg(), pickReg(), 16'($urandom));
        end else if (kind < 62) begin
            prog[i] = encodeI(OP_ORI, pickReg(), pickReg(), 16'($urandom));
        end else if (kind < 73) begin
            prog[i] = encodeI(OP_LW, pickReg(), 5'd0, 16'(slot * 4));
        end else if (kind < 84) begin
            prog[i] = encodeI(OP_SW, pickReg(), 5'd0, 16'(slot * 4));
        end else if (kind < 92) begin
            prog[i] = encodeI(OP_BEQ, pickReg(), pickReg(), 16'(skip));
        end else begin
            prog[i] = encodeI(OP_BNE, pickReg(), pickReg(), 16'(skip));
        end
    end
    // Spin in place at the end
    prog[progLen - 1] = {OP_J, 26'(progLen - 1)};
endtask

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// r0 writes are architecturally invisible
function automatic void expectWrite(regIdx_t r, word_t v);
    if (r != 5'd0) begin
        expReg.push_back(r);
        expData.push_back(v);
    end
endfunction

// In-order execution, returns 1 once the final jump is reached
function automatic bit runModel();
    word_t   mRegs [32];
    word_t   mMem [dmemWords];
    word_t   instr;
    word_t   a;
    word_t   b;
    word_t   immS;
    word_t   immZ;
    word_t   addr;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    int      pc;
    int      next;
    int      steps;
    foreach (mRegs[i]) mRegs[i] = '0;
    foreach (mMem[i]) mMem[i] = '0;
    pc = 0;
    steps = 0;
    while (pc != progLen - 1 && steps < 10 * progLen) begin
        instr = prog[pc];
        rs    = instr[25:21];
        rt    = instr[20:16];
        rd    = instr[15:11];
        a     = mRegs[rs];
        b     = mRegs[rt];
        immS  = {{16{instr[15]}}, instr[15:0]};
        immZ  = {16'd0, instr[15:0]};
        addr  = a + immS;
        next  = pc + 1;
        case (instr[31:26])
            OP_RTYPE: begin
                case (instr[5:0])
                    FN_ADD:  expectWrite(rd, a + b);
                    FN_SUB:  expectWrite(rd, a - b);
                    FN_AND:  expectWrite(rd, a & b);
                    FN_OR:   expectWrite(rd, a | b);
                    FN_SLT:  expectWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;
                endcase
                if (rd != 5'd0) mRegs[rd] = expData[$];
            end
            OP_ADDI: begin
                expectWrite(rt, a + immS);
                if (rt != 5'd0) mRegs[rt] = a + immS;
            end
            OP_ORI: begin
                expectWrite(rt, a | immZ);
                if (rt != 5'd0) mRegs[rt] = a | immZ;
            end
            OP_LW: begin
                expectWrite(rt, mMem[int'(addr[31:2]) % dmemWords]);
                if (rt != 5'd0) mRegs[rt] = mMem[int'(addr[31:2]) % dmemWords];
            end
            OP_SW:   mMem[int'(addr[31:2]) % dmemWords] = b;
            OP_BEQ:  if (a == b) next = pc + 1 + int'($signed(instr[15:0]));
            OP_BNE:  if (a != b) next = pc + 1 + int'($signed(instr[15:0]));
            OP_J:    next = int'(instr[25:0]);
            default: ;
        endcase
        pc = next;
        steps++;
    end
    return pc == progLen - 1;
endfunction

`endif

// ==== sim/tbMips.sv ====
`timescale 1ns/1ps

module tbMips;
    import mipsPkg::*;

    localparam int imemWords   = 256;
    localparam int dmemWords   = 64;
    localparam int addrW       = $clog2(imemWords);
    localparam int progLen     = 200;
    // Data slots used by loads and stores
    localparam int nSlots      = 8;
    localparam int drainLimit  = 4000;
    localparam int quietCycles = 50;

    logic             Clk;
    logic             arstN;
    logic             run;
    logic             loadEn;
    logic [addrW-1:0] loadAddr;
    word_t            loadData;
    logic             wbValid;
    regIdx_t          wbReg;
    word_t            wbData;

    // Program image and expected writeback stream
    word_t   prog [progLen];
    regIdx_t expReg [$];
    word_t   expData [$];

    int valueErrors;
    int otherErrors;
    int writesSeen;
    int cycles;
    bit modelDone;

    `include "isaModel.svh"

    mipsCore #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) dut (
        .Clk      (Clk),
        .arstN    (arstN),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    // 40 ns period
    always #20 Clk = ~Clk;

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic checkReg(input regIdx_t got, input regIdx_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %08h, expected %08h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback monitor
    ////////////////////////////////////////////////////////////

    // Falling edge, away from the stimulus edge
    always @(negedge Clk) begin
        if (arstN === 1'b1 && run === 1'b1) begin
            if (wbValid === 1'b1) begin
                writesSeen++;
                if (wbReg == 5'd0) begin
                    $display("Write strobe for register 0 at %0t", $time);
                    otherErrors++;
                end else if (expReg.size() == 0) begin
                    $display("Unexpected write to r%0d at %0t", wbReg, $time);
                    otherErrors++;
                end else begin
                    checkReg(wbReg, expReg[0], "writeback register");
                    checkWord(wbData, expData[0], "writeback data");
                    expReg.delete(0);
                    expData.delete(0);
                end
            end else if (wbValid !== 1'b0) begin
                $display("Write strobe is unknown at %0t", $time);
                otherErrors++;
            end
        end else if (wbValid !== 1'b0) begin
            // Nothing may retire in reset or while loading
            $display("Write strobe active while the core is halted at %0t", $time);
            otherErrors++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        Clk         = 1'b0;
        arstN       = 1'b0;
        run         = 1'b0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        valueErrors = 0;
        otherErrors = 0;
        writesSeen  = 0;
        void'($urandom(32'h8527));

        buildProgram();
        modelDone = runModel();
        if (!modelDone) begin
            $display("Reference model never reached the final jump");
            otherErrors++;
        end
        $display("Program of %0d instructions, %0d writes expected", progLen, expReg.size());

        // Reset for 16 cycles
        repeat (16) @(posedge Clk);
        arstN <= 1'b1;

        // Program load, core halted
        for (int i = 0; i < progLen; i++) begin
            @(posedge Clk);
            loadEn   <= 1'b1;
            loadAddr <= addrW'(i);
            loadData <= prog[i];
        end
        @(posedge Clk);
        loadEn <= 1'b0;
        @(posedge Clk);
        run <= 1'b1;

        // Drain the expected writes
        cycles = 0;
        while (expReg.size() != 0 && cycles < drainLimit) begin
            @(posedge Clk);
            cycles++;
        end
        if (expReg.size() != 0) begin
            $display("Timeout: %0d expected writes still missing after %0d cycles",
                     expReg.size(), cycles);
            otherErrors++;
        end else begin
            // Core now spins on the final jump, monitor flags any extra write
            repeat (quietCycles) @(posedge Clk);
        end

        $display("Writes seen %0d, value errors %0d, other errors %0d",
                 writesSeen, valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+sim
verilog/mipsPkg.sv
verilog/fetchUnit.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/mipsCore.sv
sim/tbMips.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tbMips
FILELIST = list.f
LOG      = sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
